//--- tb.f
+incdir+verilog
verilog/rename_pkg.sv
verilog/rat_table.sv
verilog/arf_regfile.sv
verilog/rob_alloc.sv
verilog/rename_stage.sv
dv/rename_asserts.sv
dv/rename_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the rename stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f tb.f \
    --top-module rename_tb \
    -o Vrename_tb
status=$?
if [ $status -ne 0 ]; then
    echo "build failed"
    exit $status
fi

./obj_dir/Vrename_tb +verilator+error+limit+1000
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi

exit 0

//--- dv/rename_tb.sv
`include "rename_macros.svh"
`default_nettype none

module rename_tb;

    localparam int PERIOD    = 40;
    localparam int NUM_PAIRS = 500;

    integer seed = 32'h087a_591b;

    logic clk = 1'b0;
    logic rst_n_i;
    logic flush_i;
    logic in_valid_i;
    logic in_ready_o;
    logic [1:0] in_slot_valid_i;
    logic [`XLEN-1:0] in_pc_i;
    logic [3:0][4:0] in_src_areg_i;
    logic [3:0] in_src_used_i;
    logic [1:0][4:0] in_dst_areg_i;
    logic [1:0] in_dst_wen_i;
    logic out_ready_i;
    logic [1:0] out_slot_valid_o;
    logic [`XLEN-1:0] out_pc_o;
    logic [1:0][4:0] out_dst_areg_o;
    logic [1:0] out_dst_wen_o;
    logic [1:0][`ROB_W-1:0] out_dst_tag_o;
    logic [1:0] out_dst_check_o;
    logic [3:0][`ROB_W-1:0] out_src_tag_o;
    logic [3:0][`XLEN-1:0] out_src_data_o;
    logic [3:0] out_src_ready_o;
    logic [1:0] retire_i;
    logic [1:0] retire_wen_i;
    logic [1:0][4:0] retire_areg_i;
    logic [1:0][`ROB_W-1:0] retire_tag_i;
    logic [1:0] retire_check_i;
    logic [1:0][`XLEN-1:0] retire_data_i;

    // reference model state, entry = {check, tag}
    logic [`ROB_W:0] spec_m [32];
    logic [`ROB_W:0] commit_m [32];
    logic [`XLEN-1:0] arf_m [32];
    logic [`ROB_W-1:0] next_tag;
    int count_m;
    logic avail_m;
    logic [4:0] q_areg [$];
    logic q_wen [$];
    logic [`ROB_W:0] q_ent [$];

    // predictions for the next edge and their registered copies
    logic exp_in_ready;
    logic [1:0] nxt_valid, exp_valid;
    logic [`XLEN-1:0] nxt_pc, exp_pc;
    logic [1:0][4:0] nxt_dst_areg, exp_dst_areg;
    logic [1:0] nxt_dst_wen, exp_dst_wen;
    logic [1:0][`ROB_W-1:0] nxt_dst_tag, exp_dst_tag;
    logic [1:0] nxt_dst_check, exp_dst_check;
    logic [3:0][`ROB_W-1:0] nxt_src_tag, exp_src_tag;
    logic [3:0][`XLEN-1:0] nxt_src_data, exp_src_data;
    logic [3:0] nxt_src_ready, exp_src_ready;
    logic [7:0] exp_count;

    rename_stage dut_i (.*);

    bind rename_stage rename_asserts u_asserts (
        .clk (clk), .rst_n_i (rst_n_i), .flush_i (flush_i), .out_ready_i (out_ready_i),
        .in_ready_o (in_ready_o), .out_slot_valid_o (out_slot_valid_o),
        .out_pc_o (out_pc_o), .out_dst_tag_o (out_dst_tag_o),
        .out_dst_areg_o (out_dst_areg_o), .out_dst_wen_o (out_dst_wen_o),
        .out_dst_check_o (out_dst_check_o), .out_src_tag_o (out_src_tag_o),
        .out_src_data_o (out_src_data_o), .out_src_ready_o (out_src_ready_o),
        .occupancy_i (u_rob_alloc.count_q),
        .exp_in_ready_i (rename_tb.exp_in_ready), .exp_valid_i (rename_tb.exp_valid),
        .exp_pc_i (rename_tb.exp_pc), .exp_dst_tag_i (rename_tb.exp_dst_tag),
        .exp_dst_areg_i (rename_tb.exp_dst_areg), .exp_dst_wen_i (rename_tb.exp_dst_wen),
        .exp_dst_check_i (rename_tb.exp_dst_check), .exp_src_tag_i (rename_tb.exp_src_tag),
        .exp_src_data_i (rename_tb.exp_src_data), .exp_src_ready_i (rename_tb.exp_src_ready),
        .exp_count_i (rename_tb.exp_count)
    );

    initial begin
        forever #(PERIOD/2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst_n_i) begin
            exp_valid <= '0;
            exp_count <= '0;
        end else begin
            exp_valid     <= nxt_valid;
            exp_pc        <= nxt_pc;
            exp_dst_areg  <= nxt_dst_areg;
            exp_dst_wen   <= nxt_dst_wen;
            exp_dst_tag   <= nxt_dst_tag;
            exp_dst_check <= nxt_dst_check;
            exp_src_tag   <= nxt_src_tag;
            exp_src_data  <= nxt_src_data;
            exp_src_ready <= nxt_src_ready;
            exp_count     <= 8'(count_m);
        end
    end

    always @(negedge clk) begin
        if (dut_i.u_asserts.failed) begin
            $display("** Error @%0t: assertion check failed", $time);
            $display("STATUS: FAIL");
            $fatal(1, "stopping after the first failed check");
        end
    end

    initial begin
        #(PERIOD * (NUM_PAIRS * 4 + 200));
        $display("watchdog expired before the test finished");
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    end

    function automatic int pick(input int range);
        return int'($unsigned($random(seed)) % range);
    endfunction

    task automatic run_cycle(input int retire_pct, input int stall_pct, input bit do_flush);
        logic [`ROB_W:0] cview [32];
        logic [`XLEN-1:0] aview [32];
        logic acc;
        logic [1:0] iss;
        logic [1:0][`ROB_W-1:0] tg;
        logic [`ROB_W:0] ent;
        int nret;
        @(posedge clk);
        #2;
        retire_i = '0;
        retire_wen_i = '0;
        nret = 0;
        // in-order retire, slot 1 only behind slot 0
        for (int s = 0; s < 2; s++) begin
            if (!do_flush && nret == s && q_ent.size() > 0 && pick(100) < retire_pct) begin
                retire_i[s]       = 1'b1;
                retire_wen_i[s]   = q_wen.pop_front();
                retire_areg_i[s]  = q_areg.pop_front();
                ent               = q_ent.pop_front();
                retire_tag_i[s]   = ent[`ROB_W-1:0];
                retire_check_i[s] = ent[`ROB_W];
                retire_data_i[s]  = $random(seed);
                nret++;
            end
        end
        cview = commit_m;
        aview = arf_m;
        for (int s = 0; s < 2; s++) begin
            if (retire_i[s] && retire_wen_i[s] && retire_areg_i[s] != 0) begin
                cview[retire_areg_i[s]] = {retire_check_i[s], retire_tag_i[s]};
                aview[retire_areg_i[s]] = retire_data_i[s];
            end
        end
        flush_i         = do_flush;
        out_ready_i     = (pick(100) >= stall_pct);
        in_valid_i      = (pick(4) != 0);
        in_slot_valid_i = 2'(pick(4));
        in_pc_i         = $random(seed);
        in_src_used_i   = 4'(pick(16));
        in_dst_wen_i    = 2'(pick(4));
        for (int i = 0; i < 4; i++) in_src_areg_i[i] = 5'(pick(8)); // small set, more hits
        for (int s = 0; s < 2; s++) in_dst_areg_i[s] = 5'(pick(8));
        exp_in_ready = avail_m & ~do_flush & out_ready_i;
        acc = in_valid_i & exp_in_ready;
        iss = in_slot_valid_i & {2{acc}};
        tg[0] = next_tag;
        tg[1] = iss[0] ? next_tag + 1'b1 : next_tag;
        if (out_ready_i) begin
            nxt_valid    = iss;
            nxt_pc       = in_pc_i;
            nxt_dst_areg = in_dst_areg_i;
            nxt_dst_wen  = in_dst_wen_i;
            for (int s = 0; s < 2; s++) begin
                nxt_dst_tag[s]   = tg[s];
                nxt_dst_check[s] = ~cview[in_dst_areg_i[s]][`ROB_W];
            end
            for (int i = 0; i < 4; i++) begin
                nxt_src_tag[i]   = spec_m[in_src_areg_i[i]][`ROB_W-1:0];
                nxt_src_ready[i] = ~in_src_used_i[i]
                                   | (spec_m[in_src_areg_i[i]] == cview[in_src_areg_i[i]]);
                nxt_src_data[i]  = aview[in_src_areg_i[i]];
            end
        end
        if (do_flush) begin
            nxt_valid = '0;
            for (int r = 0; r < 32; r++) begin
                spec_m[r]   = '0;
                commit_m[r] = '0;
            end
            q_areg.delete();
            q_wen.delete();
            q_ent.delete();
            next_tag = '0;
            count_m  = 0;
            avail_m  = 1'b1;
        end else begin
            commit_m = cview;
            arf_m    = aview;
            for (int s = 0; s < 2; s++) begin
                if (iss[s]) begin
                    ent = {~cview[in_dst_areg_i[s]][`ROB_W], tg[s]};
                    if (in_dst_wen_i[s] && in_dst_areg_i[s] != 0) spec_m[in_dst_areg_i[s]] = ent;
                    q_areg.push_back(in_dst_areg_i[s]);
                    q_wen.push_back(in_dst_wen_i[s]);
                    q_ent.push_back(ent);
                end
            end
            avail_m  = (count_m <= `ROB_HIGH_WATER); // from the old count
            count_m  = count_m + int'(iss[0]) + int'(iss[1]) - nret;
            next_tag = next_tag + `ROB_W'(iss[0]) + `ROB_W'(iss[1]);
        end
    endtask

    initial begin
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        in_valid_i = 1'b0;
        in_slot_valid_i = '0;
        in_pc_i = '0;
        in_src_areg_i = '0;
        in_src_used_i = '0;
        in_dst_areg_i = '0;
        in_dst_wen_i = '0;
        out_ready_i = 1'b1;
        retire_i = '0;
        retire_wen_i = '0;
        retire_areg_i = '0;
        retire_tag_i = '0;
        retire_check_i = '0;
        retire_data_i = '0;
        for (int r = 0; r < 32; r++) begin
            spec_m[r] = '0;
            commit_m[r] = '0;
            arf_m[r] = '0;
        end
        next_tag = '0;
        count_m = 0;
        avail_m = 1'b1;
        exp_in_ready = 1'b0;
        nxt_valid = '0;
        nxt_pc = '0;
        nxt_dst_areg = '0;
        nxt_dst_wen = '0;
        nxt_dst_tag = '0;
        nxt_dst_check = '0;
        nxt_src_tag = '0;
        nxt_src_data = '0;
        nxt_src_ready = '0;
        repeat (16) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        exp_in_ready = 1'b1;
        for (int n = 0; n < NUM_PAIRS; n++) begin
            if (n == 200 || n == 420) run_cycle(0, 0, 1'b1);
            else if (n < 200) run_cycle(50, 10, 1'b0);
            else if (n < 350) run_cycle(5, 0, 1'b0);  // fill past high water
            else run_cycle(90, 20, 1'b0);
        end
        run_cycle(0, 0, 1'b1); // held flush keeps the tail idle
        repeat (4) @(posedge clk);
        @(negedge clk);
        if (dut_i.u_asserts.failed) begin
            $display("STATUS: FAIL");
            $fatal(1, "checks failed");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- dv/rename_asserts.sv
`include "rename_macros.svh"
`default_nettype none

module rename_asserts (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          flush_i,
    input  logic                          out_ready_i,
    input  logic                          in_ready_o,
    input  logic [1:0]                    out_slot_valid_o,
    input  logic [`XLEN-1:0]              out_pc_o,
    input  logic [1:0][4:0]               out_dst_areg_o,
    input  logic [1:0]                    out_dst_wen_o,
    input  logic [1:0][`ROB_W-1:0]        out_dst_tag_o,
    input  logic [1:0]                    out_dst_check_o,
    input  logic [3:0][`ROB_W-1:0]        out_src_tag_o,
    input  logic [3:0][`XLEN-1:0]         out_src_data_o,
    input  logic [3:0]                    out_src_ready_o,
    input  logic [$clog2(`ROB_DEPTH+1)-1:0] occupancy_i,
    // model side
    input  logic                          exp_in_ready_i,
    input  logic [1:0]                    exp_valid_i,
    input  logic [`XLEN-1:0]              exp_pc_i,
    input  logic [1:0][4:0]               exp_dst_areg_i,
    input  logic [1:0]                    exp_dst_wen_i,
    input  logic [1:0][`ROB_W-1:0]        exp_dst_tag_i,
    input  logic [1:0]                    exp_dst_check_i,
    input  logic [3:0][`ROB_W-1:0]        exp_src_tag_i,
    input  logic [3:0][`XLEN-1:0]         exp_src_data_i,
    input  logic [3:0]                    exp_src_ready_i,
    input  logic [7:0]                    exp_count_i
);

    bit failed = 1'b0; // polled by the testbench

    a_in_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
        in_ready_o == exp_in_ready_i)
        else begin
            failed = 1'b1;
            $error("** Error @%0t: in_ready_o mismatch", $time);
        end

    a_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        out_slot_valid_o == exp_valid_i)
        else begin
            failed = 1'b1;
            $error("** Error @%0t: slot valid mismatch", $time);
        end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        (!out_ready_i && !flush_i) |=> ($stable(out_slot_valid_o) && $stable(out_pc_o)
            && $stable(out_dst_areg_o) && $stable(out_dst_wen_o)
            && $stable(out_dst_tag_o) && $stable(out_dst_check_o) && $stable(out_src_tag_o)
            && $stable(out_src_data_o) && $stable(out_src_ready_o)))
        else begin
            failed = 1'b1;
            $error("** Error @%0t: outputs moved under stall", $time);
        end

    a_full: assert property (@(posedge clk) disable iff (!rst_n_i || flush_i)
        (exp_count_i > `ROB_HIGH_WATER) |=> !in_ready_o)
        else begin
            failed = 1'b1;
            $error("** Error @%0t: ready above high water", $time);
        end

    // occupancy follows the model and never overfills
    a_depth: assert property (@(posedge clk) disable iff (!rst_n_i)
        8'(occupancy_i) == exp_count_i && occupancy_i <= `ROB_DEPTH)
        else begin
            failed = 1'b1;
            $error("** Error @%0t: ROB occupancy wrong or overfilled", $time);
        end

    for (genvar s = 0; s < 2; s++) begin : g_slot
        a_dst: assert property (@(posedge clk) disable iff (!rst_n_i)
            out_slot_valid_o[s] |-> (out_dst_tag_o[s] == exp_dst_tag_i[s]
                && out_dst_check_o[s] == exp_dst_check_i[s] && out_pc_o == exp_pc_i
                && out_dst_areg_o[s] == exp_dst_areg_i[s]
                && out_dst_wen_o[s] == exp_dst_wen_i[s]))
            else begin
                failed = 1'b1;
                $error("** Error @%0t: dst slot %0d", $time, s);
            end
    end

    for (genvar i = 0; i < 4; i++) begin : g_src
        a_src: assert property (@(posedge clk) disable iff (!rst_n_i)
            out_slot_valid_o[i/2] |-> (out_src_tag_o[i] == exp_src_tag_i[i]
                && out_src_ready_o[i] == exp_src_ready_i[i]
                && (!exp_src_ready_i[i] || out_src_data_o[i] == exp_src_data_i[i])))
            else begin
                failed = 1'b1;
                $error("** Error @%0t: source %0d", $time, i);
            end
    end

endmodule

`default_nettype wire

//--- verilog/rename_stage.sv
`include "rename_macros.svh"
`default_nettype none

module rename_stage (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            flush_i,
    input  logic                            in_valid_i,
    output logic                            in_ready_o,
    input  logic [1:0]                      in_slot_valid_i,
    input  logic [`XLEN-1:0]                in_pc_i,
    input  rename_pkg::arf_id_t [3:0]       in_src_areg_i,
    input  logic [3:0]                      in_src_used_i,
    input  rename_pkg::arf_id_t [1:0]       in_dst_areg_i,
    input  logic [1:0]                      in_dst_wen_i,
    input  logic                            out_ready_i,
    output logic [1:0]                      out_slot_valid_o,
    output logic [`XLEN-1:0]                out_pc_o,
    output rename_pkg::arf_id_t [1:0]       out_dst_areg_o,
    output logic [1:0]                      out_dst_wen_o,
    output rename_pkg::rob_id_t [1:0]       out_dst_tag_o,
    output logic [1:0]                      out_dst_check_o,
    output rename_pkg::rob_id_t [3:0]       out_src_tag_o,
    output logic [3:0][`XLEN-1:0]           out_src_data_o,
    output logic [3:0]                      out_src_ready_o,
    input  logic [1:0]                      retire_i,
    input  logic [1:0]                      retire_wen_i,
    input  rename_pkg::arf_id_t [1:0]       retire_areg_i,
    input  rename_pkg::rob_id_t [1:0]       retire_tag_i,
    input  logic [1:0]                      retire_check_i,
    input  logic [1:0][`XLEN-1:0]           retire_data_i
);

    logic                              accept;
    logic [1:0]                        issue;
    logic                              available;
    rename_pkg::rob_id_t               tag0;
    rename_pkg::rob_id_t               tag1;
    rename_pkg::rat_entry_t [3:0]      spec_rd;
    rename_pkg::rat_entry_t [1:0]      spec_new;
    logic [1:0]                        spec_we;
    rename_pkg::arf_id_t    [5:0]      commit_raddr;
    rename_pkg::rat_entry_t [5:0]      commit_rd;
    rename_pkg::rat_entry_t [1:0]      commit_new;
    logic [1:0]                        commit_we;
    logic [3:0][`XLEN-1:0]             arf_rd;
    logic [3:0]                        src_ready;

    // stall on a full ROB, a flush or downstream back-pressure
    assign in_ready_o = available & ~flush_i & out_ready_i;
    assign accept     = in_valid_i & in_ready_o;
    assign issue      = in_slot_valid_i & {2{accept}};

    rob_alloc u_rob_alloc (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .issue_i     (issue),
        .retire_i    (retire_i),
        .tag0_o      (tag0),
        .tag1_o      (tag1),
        .available_o (available)
    );

    // ports 0..3 sources, 4..5 destinations
    assign commit_raddr = {in_dst_areg_i, in_src_areg_i};

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            spec_new[s].check   = ~commit_rd[4 + s].check; // next generation
            spec_we[s]          = issue[s] & in_dst_wen_i[s] & (in_dst_areg_i[s] != '0);
            commit_new[s].check = retire_check_i[s];
            commit_new[s].robid = retire_tag_i[s];
            commit_we[s]        = retire_i[s] & retire_wen_i[s] & (retire_areg_i[s] != '0);
        end
        spec_new[0].robid = tag0;
        spec_new[1].robid = tag1;
    end

    rat_table #(
        .R_PORTS (4),
        .W_PORTS (2),
        .FORWARD (1'b0)
    ) spec_rat (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .clear_i (flush_i),
        .raddr_i (in_src_areg_i),
        .waddr_i (in_dst_areg_i),
        .we_i    (spec_we),
        .wdata_i (spec_new),
        .rdata_o (spec_rd)
    );

    rat_table #(
        .R_PORTS (6),
        .W_PORTS (2),
        .FORWARD (1'b1)
    ) commit_rat (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .clear_i (flush_i),
        .raddr_i (commit_raddr),
        .waddr_i (retire_areg_i),
        .we_i    (commit_we),
        .wdata_i (commit_new),
        .rdata_o (commit_rd)
    );

    // keeps its data across a flush
    arf_regfile u_arf (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .raddr_i (in_src_areg_i),
        .waddr_i (retire_areg_i),
        .we_i    (commit_we),
        .wdata_i (retire_data_i),
        .rdata_o (arf_rd)
    );

    // committed mapping means the value already sits in the ARF
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            src_ready[i] = ~in_src_used_i[i] | (spec_rd[i] == commit_rd[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            out_slot_valid_o <= '0;
        end else if (out_ready_i) begin
            out_slot_valid_o <= issue; // zero when nothing accepted
        end
    end

    always_ff @(posedge clk) begin
        if (out_ready_i) begin
            out_pc_o        <= in_pc_i;
            out_dst_areg_o  <= in_dst_areg_i;
            out_dst_wen_o   <= in_dst_wen_i;
            out_dst_tag_o   <= {spec_new[1].robid, spec_new[0].robid};
            out_dst_check_o <= {spec_new[1].check, spec_new[0].check};
            out_src_data_o  <= arf_rd;
            out_src_ready_o <= src_ready;
            for (int i = 0; i < 4; i++) begin
                out_src_tag_o[i] <= spec_rd[i].robid;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/rob_alloc.sv
`include "rename_macros.svh"
`default_nettype none

module rob_alloc (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic [1:0]          issue_i,
    input  logic [1:0]          retire_i,
    output rename_pkg::rob_id_t tag0_o,
    output rename_pkg::rob_id_t tag1_o,
    output logic                available_o
);

    localparam int unsigned CNT_W = $clog2(`ROB_DEPTH + 1);

    logic [CNT_W-1:0]    count_q;
    logic [1:0]          n_issue;
    logic [1:0]          n_retire;
    rename_pkg::rob_id_t tag0_q;
    rename_pkg::rob_id_t tag1_q;
    rename_pkg::rob_id_t step;
    logic                available_q;

    assign n_issue  = {1'b0, issue_i[0]} + {1'b0, issue_i[1]};
    assign n_retire = {1'b0, retire_i[0]} + {1'b0, retire_i[1]};
    assign step     = rename_pkg::rob_id_t'(n_issue);

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            count_q     <= '0;
            tag0_q      <= rename_pkg::rob_id_t'(0);
            tag1_q      <= rename_pkg::rob_id_t'(1);
            available_q <= 1'b1;
        end else begin
            count_q     <= count_q + CNT_W'(n_issue) - CNT_W'(n_retire);
            tag0_q      <= tag0_q + step;
            tag1_q      <= tag1_q + step;
            available_q <= (count_q <= CNT_W'(`ROB_HIGH_WATER)); // one cycle behind count
        end
    end

    assign tag0_o = tag0_q;
    // a lone slot 1 takes the first free tag so tags stay consecutive
    assign tag1_o = issue_i[0] ? tag1_q : tag0_q;
    assign available_o = available_q;

endmodule

`default_nettype wire

//--- verilog/arf_regfile.sv
`include "rename_macros.svh"
`default_nettype none

module arf_regfile (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  rename_pkg::arf_id_t [3:0]      raddr_i,
    input  rename_pkg::arf_id_t [1:0]      waddr_i,
    input  logic                [1:0]      we_i,
    input  logic [1:0][`XLEN-1:0]          wdata_i,
    output logic [3:0][`XLEN-1:0]          rdata_o
);

    logic [`ARF_COUNT-1:0][`XLEN-1:0] regs_q;
    logic [1:0]                       wr_en;

    // r0 is never written, so it stays at its reset value of zero
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            wr_en[w] = we_i[w] & (waddr_i[w] != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            regs_q <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (wr_en[w]) begin
                    regs_q[waddr_i[w]] <= wdata_i[w]; // port 1 wins
                end
            end
        end
    end

    // retiring value visible to same-cycle readers
    always_comb begin
        for (int r = 0; r < 4; r++) begin
            rdata_o[r] = regs_q[raddr_i[r]];
            for (int w = 0; w < 2; w++) begin
                if (wr_en[w] && (waddr_i[w] == raddr_i[r])) begin
                    rdata_o[r] = wdata_i[w];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/rat_table.sv
`include "rename_macros.svh"
`default_nettype none

module rat_table #(
    parameter int unsigned R_PORTS = 4,
    parameter int unsigned W_PORTS = 2,
    parameter bit          FORWARD = 1'b0
) (
    input  logic                                 clk,
    input  logic                                 rst_n_i,
    input  logic                                 clear_i,
    input  rename_pkg::arf_id_t    [R_PORTS-1:0] raddr_i,
    input  rename_pkg::arf_id_t    [W_PORTS-1:0] waddr_i,
    input  logic                   [W_PORTS-1:0] we_i,
    input  rename_pkg::rat_entry_t [W_PORTS-1:0] wdata_i,
    output rename_pkg::rat_entry_t [R_PORTS-1:0] rdata_o
);

    rename_pkg::rat_entry_t [`ARF_COUNT-1:0] table_q;

    // later write port overrides earlier one on same address
    always_ff @(posedge clk) begin
        if (!rst_n_i || clear_i) begin
            table_q <= '0;
        end else begin
            for (int w = 0; w < W_PORTS; w++) begin
                if (we_i[w]) begin
                    table_q[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

    always_comb begin
        for (int r = 0; r < R_PORTS; r++) begin
            rdata_o[r] = table_q[raddr_i[r]];
            if (FORWARD) begin
                // same priority as the write side
                for (int w = 0; w < W_PORTS; w++) begin
                    if (we_i[w] && (waddr_i[w] == raddr_i[r])) begin
                        rdata_o[r] = wdata_i[w];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/rename_pkg.sv
`include "rename_macros.svh"
`default_nettype none

package rename_pkg;

    typedef logic [$clog2(`ARF_COUNT)-1:0] arf_id_t; // architectural register number

    typedef logic [`ROB_W-1:0] rob_id_t;

    // one alias table entry
    typedef struct packed {
        logic    check; // generation bit of the mapping
        rob_id_t robid;
    } rat_entry_t;

endpackage

`default_nettype wire

//--- verilog/rename_macros.svh
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// architectural state
`define ARF_COUNT 32
`define XLEN 32

// reorder buffer sizing
`define ROB_DEPTH 64
`define ROB_W 6

// stop allocating above this occupancy
`define ROB_HIGH_WATER 60

`endif
